//--- rtl/memPkg.sv
package memPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// One machine word
	localparam int DataWidth = 18;

	// Full word address, 16 bank slots of 1024 words
	localparam int AddrWidth = 14;

	// Word address inside one bank
	localparam int BankAddrWidth = 10;

	// Upper address bits that pick the bank
	localparam int BankSelWidth = AddrWidth - BankAddrWidth;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic {
		opRead  = 1'b0,
		opWrite = 1'b1
	} memOp_t;

	// Controller states
	typedef enum logic {
		stInit = 1'b0,
		stRun  = 1'b1
	} ctrlState_t;

	//////////////////////////////////////////////////////////////////////
	// Port payloads
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		memOp_t                 op;
		logic [AddrWidth-1:0]   addr;
		logic [DataWidth-1:0]   data;
	} memReq_t;

	// Read data, or the old word for a write
	typedef struct packed {
		logic [DataWidth-1:0]   data;
	} memResp_t;

endpackage

//--- rtl/blockRam.sv
module blockRam #(
	parameter int DataWidth = memPkg::DataWidth,
	parameter int AddrWidth = memPkg::BankAddrWidth
) (
	input  logic                 clka,
	input  logic                 weA,
	input  logic                 weB,
	input  logic [AddrWidth-1:0] addrA,
	input  logic [AddrWidth-1:0] addrB,
	input  logic [DataWidth-1:0] dinA,
	input  logic [DataWidth-1:0] dinB,
	output logic [DataWidth-1:0] doutA,
	output logic [DataWidth-1:0] doutB
);

	localparam int Depth = 1 << AddrWidth;

	// Contents undefined until written
	logic [DataWidth-1:0] mem [Depth];

	// Port A, old word out then write
	always @(posedge clka)
	begin
		doutA <= mem[addrA];
		if (weA)
		begin
			mem[addrA] <= dinA;
		end
	end

	// Port B, same read-first order
	always @(posedge clka)
	begin
		doutB <= mem[addrB];
		if (weB)
		begin
			mem[addrB] <= dinB;
		end
	end

endmodule

//--- rtl/mainMem.sv
module mainMem #(
	parameter int NumBanks = 11
) (
	input  logic                           clka,
	input  logic                           weA,
	input  logic                           weB,
	input  logic [memPkg::AddrWidth-1:0]   addrA,
	input  logic [memPkg::AddrWidth-1:0]   addrB,
	input  logic [memPkg::DataWidth-1:0]   dinA,
	input  logic [memPkg::DataWidth-1:0]   dinB,
	output memPkg::memResp_t               doutA,
	output memPkg::memResp_t               doutB
);

	logic [memPkg::BankSelWidth-1:0] bankSelA;
	logic [memPkg::BankSelWidth-1:0] bankSelB;
	logic [memPkg::BankSelWidth-1:0] bankSelQA;
	logic [memPkg::BankSelWidth-1:0] bankSelQB;

	logic [NumBanks-1:0] bankWeA;
	logic [NumBanks-1:0] bankWeB;

	logic [memPkg::DataWidth-1:0] bankDoutA [NumBanks];
	logic [memPkg::DataWidth-1:0] bankDoutB [NumBanks];

	assign bankSelA = addrA[memPkg::AddrWidth-1:memPkg::BankAddrWidth];
	assign bankSelB = addrB[memPkg::AddrWidth-1:memPkg::BankAddrWidth];

	// Select follows the RAM by one clock
	always_ff @(posedge clka)
	begin
		bankSelQA <= bankSelA;
		bankSelQB <= bankSelB;
	end

	//////////////////////////////////////////////////////////////////////
	// Banks
	//////////////////////////////////////////////////////////////////////

	// Absent bank slots get no RAM, so writes there go nowhere
	for (genvar g = 0; g < NumBanks; g++)
	begin : genBank
		assign bankWeA[g] = weA && (bankSelA == memPkg::BankSelWidth'(g));
		assign bankWeB[g] = weB && (bankSelB == memPkg::BankSelWidth'(g));

		blockRam #(
			.DataWidth (memPkg::DataWidth),
			.AddrWidth (memPkg::BankAddrWidth)
		) bank (
			.clka  (clka),
			.weA   (bankWeA[g]),
			.weB   (bankWeB[g]),
			.addrA (addrA[memPkg::BankAddrWidth-1:0]),
			.addrB (addrB[memPkg::BankAddrWidth-1:0]),
			.dinA  (dinA),
			.dinB  (dinB),
			.doutA (bankDoutA[g]),
			.doutB (bankDoutB[g])
		);
	end

	// Output mux, zero for absent banks
	always_comb
	begin
		doutA = '0;
		doutB = '0;
		for (int i = 0; i < NumBanks; i++)
		begin
			if (bankSelQA == memPkg::BankSelWidth'(i))
			begin
				doutA.data = bankDoutA[i];
			end
			if (bankSelQB == memPkg::BankSelWidth'(i))
			begin
				doutB.data = bankDoutB[i];
			end
		end
	end

endmodule

//--- rtl/reqQueue.sv
module reqQueue #(
	parameter int QueueDepth = 4
) (
	input  logic             clka,
	input  logic             rstN,
	input  logic             push,
	input  memPkg::memReq_t  pushData,
	input  logic             pop,
	output memPkg::memReq_t  head,
	output logic             empty
);

	localparam int PtrWidth = $clog2(QueueDepth);
	localparam int CountWidth = $clog2(QueueDepth + 1);

	memPkg::memReq_t entries [QueueDepth];

	logic [PtrWidth-1:0]   wrPtr;
	logic [PtrWidth-1:0]   rdPtr;
	logic [CountWidth-1:0] count;

	// Oldest entry sits at the read pointer
	assign head = entries[rdPtr];
	assign empty = (count == '0);

	always_ff @(posedge clka)
	begin
		if (push)
		begin
			entries[wrPtr] <= pushData;
		end
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clka or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/memController.sv
module memController #(
	parameter int QueueDepth = 4
) (
	input  logic                           clka,
	input  logic                           rstN,
	input  logic                           emptyA,
	input  memPkg::memReq_t                headA,
	input  logic                           emptyB,
	input  memPkg::memReq_t                headB,
	output logic                           popA,
	output logic                           popB,
	output logic                           creditA,
	output logic                           creditB,
	output logic                           weA,
	output logic                           weB,
	output logic [memPkg::AddrWidth-1:0]   addrA,
	output logic [memPkg::AddrWidth-1:0]   addrB,
	output logic [memPkg::DataWidth-1:0]   dinA,
	output logic [memPkg::DataWidth-1:0]   dinB,
	output logic                           respValidA,
	output logic                           respValidB
);

	localparam int CountWidth = $clog2(QueueDepth);

	memPkg::ctrlState_t state;
	logic [CountWidth-1:0] initCount;
	logic inInit;

	assign inInit = (state == memPkg::stInit);

	//////////////////////////////////////////////////////////////////////
	// Credit announcement FSM
	//////////////////////////////////////////////////////////////////////

	// One credit per queue slot, then normal running
	always_ff @(posedge clka or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= memPkg::stInit;
			initCount <= '0;
		end
		else if (inInit)
		begin
			initCount <= initCount + 1'b1;
			if (initCount == CountWidth'(QueueDepth - 1))
			begin
				state <= memPkg::stRun;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Issue
	//////////////////////////////////////////////////////////////////////

	// Ports run independently, one request each per clock
	assign popA = !inInit && !emptyA;
	assign popB = !inInit && !emptyB;

	assign weA = popA && (headA.op == memPkg::opWrite);
	assign weB = popB && (headB.op == memPkg::opWrite);

	// Head goes straight to the banks
	assign addrA = headA.addr;
	assign addrB = headB.addr;
	assign dinA = headA.data;
	assign dinB = headB.data;

	//////////////////////////////////////////////////////////////////////
	// Credits and response strobes
	//////////////////////////////////////////////////////////////////////

	// Credit trails its init cycle or pop by one clock
	// respValid lines up with the RAM output register
	always_ff @(posedge clka or negedge rstN)
	begin
		if (!rstN)
		begin
			creditA <= 1'b0;
			creditB <= 1'b0;
			respValidA <= 1'b0;
			respValidB <= 1'b0;
		end
		else
		begin
			creditA <= inInit || popA;
			creditB <= inInit || popB;
			respValidA <= popA;
			respValidB <= popB;
		end
	end

endmodule

//--- rtl/memSubsystem.sv
module memSubsystem #(
	parameter int NumBanks = 11,
	parameter int QueueDepth = 4
) (
	input  logic             clka,
	input  logic             rstN,
	input  memPkg::memReq_t  reqA,
	input  logic             reqValidA,
	output logic             creditA,
	output memPkg::memResp_t respA,
	output logic             respValidA,
	input  memPkg::memReq_t  reqB,
	input  logic             reqValidB,
	output logic             creditB,
	output memPkg::memResp_t respB,
	output logic             respValidB
);

	memPkg::memReq_t headA;
	memPkg::memReq_t headB;
	logic emptyA;
	logic emptyB;
	logic popA;
	logic popB;

	// Memory command per port
	logic weA;
	logic weB;
	logic [memPkg::AddrWidth-1:0] addrA;
	logic [memPkg::AddrWidth-1:0] addrB;
	logic [memPkg::DataWidth-1:0] dinA;
	logic [memPkg::DataWidth-1:0] dinB;

	reqQueue #(
		.QueueDepth (QueueDepth)
	) queueA (
		.clka     (clka),
		.rstN     (rstN),
		.push     (reqValidA),
		.pushData (reqA),
		.pop      (popA),
		.head     (headA),
		.empty    (emptyA)
	);

	reqQueue #(
		.QueueDepth (QueueDepth)
	) queueB (
		.clka     (clka),
		.rstN     (rstN),
		.push     (reqValidB),
		.pushData (reqB),
		.pop      (popB),
		.head     (headB),
		.empty    (emptyB)
	);

	memController #(
		.QueueDepth (QueueDepth)
	) memController_inst (
		.clka       (clka),
		.rstN       (rstN),
		.emptyA     (emptyA),
		.headA      (headA),
		.emptyB     (emptyB),
		.headB      (headB),
		.popA       (popA),
		.popB       (popB),
		.creditA    (creditA),
		.creditB    (creditB),
		.weA        (weA),
		.weB        (weB),
		.addrA      (addrA),
		.addrB      (addrB),
		.dinA       (dinA),
		.dinB       (dinB),
		.respValidA (respValidA),
		.respValidB (respValidB)
	);

	mainMem #(
		.NumBanks (NumBanks)
	) mainMem_inst (
		.clka  (clka),
		.weA   (weA),
		.weB   (weB),
		.addrA (addrA),
		.addrB (addrB),
		.dinA  (dinA),
		.dinB  (dinB),
		.doutA (respA),
		.doutB (respB)
	);

endmodule

//--- verification/memController_properties.sv
module memController_properties (
	input logic clka,
	input logic rstN,
	input logic inInit,
	input logic emptyA,
	input logic emptyB,
	input logic popA,
	input logic popB,
	input logic creditA,
	input logic creditB,
	input logic respValidA,
	input logic respValidB
);

	// Quiet outputs while held in reset
	resetQuiet: assert property (@(posedge clka)
		!rstN |-> !creditA && !creditB && !respValidA && !respValidB && !popA && !popB)
	else $error("Credit, pop or response active during reset");

	// Each init cycle announces one slot per port
	initCredit: assert property (@(posedge clka) disable iff (!rstN)
		inInit |=> creditA && creditB)
	else $error("Credit missing after an init cycle");

	creditOnlyOnPopA: assert property (@(posedge clka) disable iff (!rstN)
		!inInit && !popA |=> !creditA)
	else $error("Port A credit without a pop");

	creditOnlyOnPopB: assert property (@(posedge clka) disable iff (!rstN)
		!inInit && !popB |=> !creditB)
	else $error("Port B credit without a pop");

	popNotEmptyA: assert property (@(posedge clka) disable iff (!rstN) popA |-> !emptyA)
	else $error("Pop on empty port A queue");

	popNotEmptyB: assert property (@(posedge clka) disable iff (!rstN) popB |-> !emptyB)
	else $error("Pop on empty port B queue");

	// One RAM cycle from issue to response strobe
	respAfterPopA: assert property (@(posedge clka) disable iff (!rstN)
		respValidA == $past(popA))
	else $error("Port A respValid does not trail its pop by one cycle");

	respAfterPopB: assert property (@(posedge clka) disable iff (!rstN)
		respValidB == $past(popB))
	else $error("Port B respValid does not trail its pop by one cycle");

endmodule

bind memController memController_properties memController_properties_inst (
	.clka       (clka),
	.rstN       (rstN),
	.inInit     (inInit),
	.emptyA     (emptyA),
	.emptyB     (emptyB),
	.popA       (popA),
	.popB       (popB),
	.creditA    (creditA),
	.creditB    (creditB),
	.respValidA (respValidA),
	.respValidB (respValidB)
);

//--- verification/memSubsystemTb.sv
module memSubsystemTb;

	localparam int NumBanks = 11;
	localparam int QueueDepth = 4;
	localparam int ClockPeriod = 20;
	localparam int ResetCycles = 16;
	localparam int DriveDelay = 2;
	localparam int Timeout = 200;
	localparam int MaxPending = 256;
	localparam int RandomCount = 16;
	localparam int PopulatedWords = NumBanks * 1024;

	// Things the driver can wait for
	localparam int WaitInitCredits = 0;
	localparam int WaitRowCredits = 1;
	localparam int WaitDrained = 2;

	typedef struct packed {
		logic                         active;
		logic                         check;
		memPkg::memReq_t              req;
		logic [memPkg::DataWidth-1:0] expData;
	} sideCmd_t;

	// One row drives both ports in the same cycle
	typedef struct packed {
		logic     drain;
		sideCmd_t a;
		sideCmd_t b;
	} stimRow_t;

	localparam sideCmd_t NoCmd = '0;

	logic clka;
	logic rstN;
	memPkg::memReq_t reqA;
	logic reqValidA;
	logic creditA;
	memPkg::memResp_t respA;
	logic respValidA;
	memPkg::memReq_t reqB;
	logic reqValidB;
	logic creditB;
	memPkg::memResp_t respB;
	logic respValidB;

	stimRow_t stimRows [$];
	string stimNames [$];
	stimRow_t nextRow;

	// Expected responses per port, index 0 is port A
	logic [memPkg::DataWidth-1:0] pendData [2][MaxPending];
	bit pendCheck [2][MaxPending];
	int pendCycle [2][MaxPending];
	string pendName [2][MaxPending];
	int sentCount [2];
	int gotCount [2];
	int lastRespCycle [2];
	int creditsUsed [2];
	int creditsGot [2];

	int cycle;
	int checkErrors;
	int setupErrors;
	bit timedOut;
	integer seed = 22;

	// Scoreboard for the random phase
	logic [memPkg::DataWidth-1:0] model [PopulatedWords];
	bit known [PopulatedWords];

	memSubsystem #(
		.NumBanks   (NumBanks),
		.QueueDepth (QueueDepth)
	) memSubsystem_inst (
		.clka       (clka),
		.rstN       (rstN),
		.reqA       (reqA),
		.reqValidA  (reqValidA),
		.creditA    (creditA),
		.respA      (respA),
		.respValidA (respValidA),
		.reqB       (reqB),
		.reqValidB  (reqValidB),
		.creditB    (creditB),
		.respB      (respB),
		.respValidB (respValidB)
	);

	initial
	begin
		clka = 1'b0;
		forever #(ClockPeriod / 2) clka = ~clka;
	end

	always @(posedge clka)
	begin
		cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	function automatic sideCmd_t readCmd(input logic [13:0] addr, input logic [17:0] expData);
		sideCmd_t c;
		c = '0;
		c.active = 1'b1;
		c.check = 1'b1;
		c.req.op = memPkg::opRead;
		c.req.addr = addr;
		c.expData = expData;
		return c;
	endfunction

	// check low when the old word is still unknown
	function automatic sideCmd_t writeCmd(input logic [13:0] addr, input logic [17:0] data,
		input logic check, input logic [17:0] expData);
		sideCmd_t c;
		c.active = 1'b1;
		c.check = check;
		c.req.op = memPkg::opWrite;
		c.req.addr = addr;
		c.req.data = data;
		c.expData = expData;
		return c;
	endfunction

	task automatic addRow(input string name, input logic drain, input sideCmd_t a,
		input sideCmd_t b);
		stimRow_t r;
		r.drain = drain;
		r.a = a;
		r.b = b;
		stimRows.push_back(r);
		stimNames.push_back(name);
	endtask

	task automatic buildTable();
		addRow("write then read", 1'b0, writeCmd(14'h0010, 18'h12345, 1'b0, '0), NoCmd);
		addRow("write then read", 1'b0, readCmd(14'h0010, 18'h12345), NoCmd);
		addRow("read-first write", 1'b0, writeCmd(14'h0010, 18'h2abcd, 1'b1, 18'h12345), NoCmd);
		addRow("read-first write", 1'b0, readCmd(14'h0010, 18'h2abcd), NoCmd);
		// Bank 0, bank 5 and bank 10 written from the opposite port
		addRow("cross port", 1'b0, writeCmd(14'h1404, 18'h0a5a5, 1'b0, '0),
			writeCmd(14'h0003, 18'h00111, 1'b0, '0));
		addRow("cross port", 1'b0, writeCmd(14'h2800, 18'h15555, 1'b0, '0),
			writeCmd(14'h2bff, 18'h3ffff, 1'b0, '0));
		addRow("cross port", 1'b1, readCmd(14'h0003, 18'h00111), readCmd(14'h1404, 18'h0a5a5));
		addRow("cross port", 1'b0, readCmd(14'h2bff, 18'h3ffff), readCmd(14'h2800, 18'h15555));
		addRow("absent bank", 1'b0, readCmd(14'h2c00, '0), readCmd(14'h3fff, '0));
		addRow("absent bank", 1'b0, writeCmd(14'h3010, 18'h1f0f0, 1'b1, '0),
			writeCmd(14'h2c03, 18'h22222, 1'b1, '0));
		addRow("absent bank", 1'b0, readCmd(14'h3010, '0), readCmd(14'h2c03, '0));
		// Same offsets in bank 0 keep their words
		addRow("absent bank", 1'b0, readCmd(14'h0010, 18'h2abcd), readCmd(14'h0003, 18'h00111));
		addRow("burst", 1'b1, writeCmd(14'h0400, 18'h00001, 1'b0, '0),
			writeCmd(14'h0800, 18'h00002, 1'b0, '0));
		addRow("burst", 1'b0, writeCmd(14'h0401, 18'h00003, 1'b0, '0),
			writeCmd(14'h0801, 18'h00004, 1'b0, '0));
		addRow("burst", 1'b0, readCmd(14'h0400, 18'h00001), readCmd(14'h0800, 18'h00002));
		addRow("burst", 1'b0, readCmd(14'h0401, 18'h00003), readCmd(14'h0801, 18'h00004));
		addRow("burst", 1'b0, writeCmd(14'h0400, 18'h00005, 1'b1, 18'h00001),
			writeCmd(14'h0800, 18'h00006, 1'b1, 18'h00002));
		addRow("burst", 1'b0, readCmd(14'h0400, 18'h00005), readCmd(14'h0800, 18'h00006));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driver
	//////////////////////////////////////////////////////////////////////

	function automatic bit conditionMet(input int kind);
		case (kind)
			WaitInitCredits: return creditsGot[0] >= QueueDepth && creditsGot[1] >= QueueDepth;
			WaitRowCredits: return !(nextRow.a.active && creditsGot[0] == creditsUsed[0])
				&& !(nextRow.b.active && creditsGot[1] == creditsUsed[1]);
			default: return gotCount[0] == sentCount[0] && gotCount[1] == sentCount[1];
		endcase
	endfunction

	task automatic waitFor(input int kind, input string what);
		int waited;
		waited = 0;
		while (!conditionMet(kind) && waited < Timeout)
		begin
			@(posedge clka);
			#DriveDelay;
			waited++;
		end
		if (!conditionMet(kind))
		begin
			$display("Timed out after %0d cycles waiting for %s", Timeout, what);
			timedOut = 1'b1;
		end
	endtask

	task automatic recordRequest(input int p, input string name, input sideCmd_t c);
		int due;
		assert (creditsUsed[p] < creditsGot[p])
		else
		begin
			setupErrors++;
			$display("Request for %s sent on port %0d without a credit", name, p);
		end
		// Two cycles on an empty queue, one more per entry ahead
		due = cycle + 2;
		if (lastRespCycle[p] + 1 > due)
		begin
			due = lastRespCycle[p] + 1;
		end
		pendData[p][sentCount[p]] = c.expData;
		pendCheck[p][sentCount[p]] = c.check;
		pendCycle[p][sentCount[p]] = due;
		pendName[p][sentCount[p]] = name;
		lastRespCycle[p] = due;
		creditsUsed[p]++;
		sentCount[p]++;
	endtask

	task automatic applyRow(input string name, input stimRow_t r);
		if (r.drain)
		begin
			waitFor(WaitDrained, "responses before a new row");
		end
		nextRow = r;
		if (!timedOut)
		begin
			waitFor(WaitRowCredits, "a credit");
		end
		if (timedOut)
		begin
			return;
		end
		reqA = r.a.req;
		reqValidA = r.a.active;
		reqB = r.b.req;
		reqValidB = r.b.active;
		if (r.a.active)
		begin
			recordRequest(0, name, r.a);
		end
		if (r.b.active)
		begin
			recordRequest(1, name, r.b);
		end
		@(posedge clka);
		#DriveDelay;
		reqValidA = 1'b0;
		reqValidB = 1'b0;
	endtask

	task automatic runRandom();
		int addrs [RandomCount];
		int a;
		logic [17:0] d;
		stimRow_t r;
		for (int i = 0; i < 2 * RandomCount; i++)
		begin
			r = '0;
			if (i < RandomCount)
			begin
				a = int'($unsigned($random(seed)) % PopulatedWords);
				d = 18'($random(seed));
				addrs[i] = a;
				r.a = writeCmd(14'(a), d, known[a], model[a]);
				model[a] = d;
				known[a] = 1'b1;
			end
			else
			begin
				r.a = readCmd(14'(addrs[i - RandomCount]), model[addrs[i - RandomCount]]);
			end
			if (($random(seed) & 1) != 0)
			begin
				r.b = r.a;
				r.a = NoCmd;
			end
			applyRow(i < RandomCount ? "random write" : "random read", r);
			if (timedOut)
			begin
				return;
			end
		end
	endtask

	task automatic runTests();
		waitFor(WaitInitCredits, "the initial credits");
		if (timedOut)
		begin
			return;
		end
		// stInit is over, later pulses would be extra credits
		repeat (2) @(posedge clka);
		#DriveDelay;
		assert (creditsGot[0] == QueueDepth && creditsGot[1] == QueueDepth)
		else
		begin
			setupErrors++;
			$display("FAIL initial credits: expected %0d, actual %0d and %0d", QueueDepth,
				creditsGot[0], creditsGot[1]);
		end
		foreach (stimRows[i])
		begin
			applyRow(stimNames[i], stimRows[i]);
			if (timedOut)
			begin
				return;
			end
		end
		runRandom();
		if (!timedOut)
		begin
			waitFor(WaitDrained, "the last responses");
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		reqA = '0;
		reqValidA = 1'b0;
		reqB = '0;
		reqValidB = 1'b0;
		buildTable();
		repeat (ResetCycles) @(posedge clka);
		#DriveDelay;
		rstN = 1'b1;
		runTests();
		$display("Check errors: %0d, setup errors: %0d, timeouts: %0d", checkErrors,
			setupErrors, timedOut);
		if (checkErrors == 0 && setupErrors == 0 && !timedOut)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Monitor
	//////////////////////////////////////////////////////////////////////

	task automatic countCredit(input int p);
		creditsGot[p]++;
		assert (creditsGot[p] - creditsUsed[p] <= QueueDepth)
		else
		begin
			checkErrors++;
			$display("Port %0d returned more credits than its queue holds", p);
		end
	endtask

	task automatic checkResponse(input int p, input logic [17:0] actual);
		int idx;
		idx = gotCount[p];
		assert (idx < sentCount[p])
		else
		begin
			checkErrors++;
			$display("Response on port %0d with no request outstanding", p);
		end
		if (idx < sentCount[p])
		begin
			if (pendCheck[p][idx])
			begin
				assert (actual === pendData[p][idx])
				else
				begin
					checkErrors++;
					$display("FAIL %s port %0d data: expected %h, actual %h", pendName[p][idx], p,
						pendData[p][idx], actual);
				end
			end
			assert (cycle == pendCycle[p][idx])
			else
			begin
				checkErrors++;
				$display("FAIL %s port %0d cycle: expected %0d, actual %0d", pendName[p][idx], p,
					pendCycle[p][idx], cycle);
			end
			gotCount[p]++;
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clka)
	begin
		if (creditA)
		begin
			countCredit(0);
		end
		if (creditB)
		begin
			countCredit(1);
		end
		if (respValidA)
		begin
			checkResponse(0, respA.data);
		end
		if (respValidB)
		begin
			checkResponse(1, respB.data);
		end
	end

endmodule

//--- vlog.f
rtl/memPkg.sv
rtl/blockRam.sv
rtl/mainMem.sv
rtl/reqQueue.sv
rtl/memController.sv
rtl/memSubsystem.sv
verification/memController_properties.sv
verification/memSubsystemTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = memSubsystemTb
FILELIST = vlog.f
OBJDIR   = obj_dir
SIMBIN   = $(OBJDIR)/V$(TOP)
LOG      = sim.log
FAILMSG  = Errors found
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
